// ==== hw/uart_pkg.sv ====
`default_nettype none

// shared types for the uart subsystem
package uart_pkg;

  // divider ratio width, the ratio is a runtime input
  localparam int RATIO_W = 20;

  // payload width, fixed at one byte
  localparam int DATA_W = 8;

  // one payload byte
  typedef logic [DATA_W-1:0] uart_data_t;

  // oversample divider ratio
  typedef logic [RATIO_W-1:0] uart_ratio_t;

  // frame configuration, shared by tx and rx
  typedef struct packed {
    logic parity_en;   // parity bit sent and checked
    logic parity_odd;  // odd parity when set, even otherwise
  } uart_cfg_t;

  // receive status, updated with every received byte
  typedef struct packed {
    logic parity_err;  // parity bit disagrees with data
    logic frame_err;   // stop bit sampled low
  } uart_rx_status_t;

endpackage

`default_nettype wire

// ==== hw/uart_clk_div.sv ====
`timescale 1ns/10ps
`default_nettype none

// oversample clock divider
// divides the reference clock by a runtime ratio, odd ratios get a longer low phase
// ratio 0 or 1, or enable low, passes the reference clock straight through
module uart_clk_div (
  input  logic                  i_clk_div_ref_clk,
  input  logic                  i_clk_div_rst,
  input  logic                  i_clk_div_clk_en,
  input  uart_pkg::uart_ratio_t i_clk_div_ratio,
  output logic                  o_clk_div_baud_clk
);

  import uart_pkg::*;

  uart_ratio_t cnt;      // reference cycles spent in the current phase
  uart_ratio_t half;     // ratio / 2, rounded down
  uart_ratio_t target;   // last count of the current phase
  logic        div_en;   // divider actually running
  logic        div_clk;  // divided clock, low after reset, also the phase flag
  logic        toggle;   // end of the current phase

  // ratio 0 and 1 fall back to the reference clock
  assign div_en = i_clk_div_clk_en && (i_clk_div_ratio > uart_ratio_t'(1));

  assign half = i_clk_div_ratio >> 1;

  // even ratio: both phases half long
  // odd ratio: low phase is half + 1, high phase is half
  assign target = (!div_clk && i_clk_div_ratio[0]) ? half : half - uart_ratio_t'(1);

  // >= so that a smaller ratio never runs the count away
  assign toggle = (cnt >= target);

  always_ff @(posedge i_clk_div_ref_clk or posedge i_clk_div_rst)
  begin
    if (i_clk_div_rst)
    begin
      cnt     <= '0;
      div_clk <= 1'b0;
    end
    else if (!div_en)
    begin
      // parked low, the next low phase starts from zero
      cnt     <= '0;
      div_clk <= 1'b0;
    end
    else if (toggle)
    begin
      div_clk <= ~div_clk;
      cnt     <= '0;
    end
    else
    begin
      cnt <= cnt + uart_ratio_t'(1);  // still inside the phase
    end
  end

  // bypass mux, divided clock only while the divider runs
  assign o_clk_div_baud_clk = div_en ? div_clk : i_clk_div_ref_clk;

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

// uart transmitter
// start bit, 8 data bits lsb first, optional parity, one stop bit
// every bit is PRESCALE oversample cycles long
module uart_tx #(
  parameter int PRESCALE = 8  // oversample cycles per bit, even and >= 4
) (
  input  logic                 i_clk_div_ref_clk,  // oversample clock
  input  logic                 i_clk_div_rst,
  input  uart_pkg::uart_cfg_t  i_cfg,
  input  uart_pkg::uart_data_t i_tx_data,
  input  logic                 i_tx_valid,         // level, held until busy seen
  output logic                 o_tx_serial,
  output logic                 o_tx_busy
);

  import uart_pkg::*;

  localparam int                TICK_W    = $clog2(PRESCALE);
  localparam int                BIT_W     = $clog2(DATA_W);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(PRESCALE - 1);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(DATA_W - 1);

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_t;

  tx_state_t         state;
  logic [TICK_W-1:0] tick;     // oversample cycle inside the bit
  logic [BIT_W-1:0]  bit_idx;  // data bit on the line
  logic              bit_end;  // last cycle of the current bit
  logic              accept;   // new frame taken this edge
  uart_data_t        shreg;    // byte, shifted out lsb first
  uart_cfg_t         cfg_q;    // config frozen for the whole frame
  logic              par_q;    // running parity over bits already sent

  assign bit_end = (tick == TICK_LAST);
  assign accept  = (state == TX_IDLE) && i_tx_valid;

  // control FSM
  always_ff @(posedge i_clk_div_ref_clk or posedge i_clk_div_rst)
  begin
    if (i_clk_div_rst)
    begin
      state       <= TX_IDLE;
      tick        <= '0;
      bit_idx     <= '0;
      o_tx_serial <= 1'b1;  // line idles high
      o_tx_busy   <= 1'b0;
    end
    else
    begin
      if (state == TX_IDLE)
        tick <= '0;
      else
        tick <= bit_end ? '0 : tick + 1'b1;  // wraps once per bit

      case (state)
        TX_IDLE:
        begin
          if (accept)
          begin
            state       <= TX_START;
            bit_idx     <= '0;
            o_tx_serial <= 1'b0;  // start bit goes out on the accepting edge
            o_tx_busy   <= 1'b1;
          end
        end
        TX_START:
        begin
          if (bit_end)
          begin
            state       <= TX_DATA;
            o_tx_serial <= shreg[0];  // first data bit
          end
        end
        TX_DATA:
        begin
          if (bit_end)
          begin
            if (bit_idx == BIT_LAST)
            begin
              if (cfg_q.parity_en)
              begin
                state       <= TX_PARITY;
                o_tx_serial <= par_q ^ shreg[0];  // fold in the last data bit
              end
              else
              begin
                state       <= TX_STOP;
                o_tx_serial <= 1'b1;
              end
            end
            else
            begin
              bit_idx     <= bit_idx + 1'b1;
              o_tx_serial <= shreg[1];  // next bit, shreg shifts on this edge
            end
          end
        end
        TX_PARITY:
        begin
          if (bit_end)
          begin
            state       <= TX_STOP;
            o_tx_serial <= 1'b1;
          end
        end
        TX_STOP:
        begin
          if (bit_end)
          begin
            state     <= TX_IDLE;
            o_tx_busy <= 1'b0;  // frame done, line stays high
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // payload, captured at accept and shifted at each data bit end
  always_ff @(posedge i_clk_div_ref_clk)
  begin
    if (accept)
    begin
      shreg <= i_tx_data;
      cfg_q <= i_cfg;
      par_q <= i_cfg.parity_odd;  // odd parity starts from one
    end
    else if ((state == TX_DATA) && bit_end)
    begin
      par_q <= par_q ^ shreg[0];
      shreg <= shreg >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

// uart receiver
// two-flop sync on the line, start detect with mid-bit recheck,
// majority of three samples per bit, parity and stop checks
module uart_rx #(
  parameter int PRESCALE = 8  // oversample cycles per bit, even and >= 4
) (
  input  logic                       i_clk_div_ref_clk,  // oversample clock
  input  logic                       i_clk_div_rst,
  input  uart_pkg::uart_cfg_t        i_cfg,
  input  logic                       i_rx_serial,
  output uart_pkg::uart_data_t       o_rx_data,
  output logic                       o_rx_valid,         // one cycle pulse at mid stop
  output uart_pkg::uart_rx_status_t  o_rx_status
);

  import uart_pkg::*;

  localparam int                TICK_W    = $clog2(PRESCALE);
  localparam int                BIT_W     = $clog2(DATA_W);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(PRESCALE - 1);
  localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(PRESCALE / 2);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(DATA_W - 1);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP,
    RX_WAIT    // stop seen, wait for a high line before the next start
  } rx_state_t;

  rx_state_t         state;
  logic              rx_meta;  // first sync stage
  logic              rx_sync;  // synchronized line
  logic [1:0]        hist;     // two previous synchronized samples
  logic              vote;     // majority of hist and rx_sync
  logic [TICK_W-1:0] tick;     // index of the sample taken this edge
  logic [BIT_W-1:0]  bit_idx;
  logic              mid;      // last of the three votes of a bit
  logic              bit_end;
  uart_data_t        shreg;    // data bits, filled from the msb side
  logic              par_bit;  // received parity bit
  logic              par_exp;  // parity bit expected for shreg

  // samples P/2-2, P/2-1 and P/2 of the bit, the middle pair straddles the centre
  assign vote    = (hist[1] & hist[0]) | (hist[1] & rx_sync) | (hist[0] & rx_sync);
  assign mid     = (tick == TICK_MID);
  assign bit_end = (tick == TICK_LAST);
  assign par_exp = (^shreg) ^ i_cfg.parity_odd;

  // line synchronizer, idles high
  always_ff @(posedge i_clk_div_ref_clk or posedge i_clk_div_rst)
  begin
    if (i_clk_div_rst)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= i_rx_serial;
      rx_sync <= rx_meta;
    end
  end

  // control FSM
  always_ff @(posedge i_clk_div_ref_clk or posedge i_clk_div_rst)
  begin
    if (i_clk_div_rst)
    begin
      state       <= RX_IDLE;
      tick        <= '0;
      bit_idx     <= '0;
      o_rx_valid  <= 1'b0;
      o_rx_status <= '0;
    end
    else
    begin
      o_rx_valid <= 1'b0;  // pulse lasts one cycle

      if ((state == RX_IDLE) || (state == RX_WAIT))
        tick <= TICK_W'(1);  // a start seen now is sample 0
      else
        tick <= bit_end ? '0 : tick + 1'b1;

      case (state)
        RX_IDLE:
        begin
          if (!rx_sync)
          begin
            state   <= RX_START;
            bit_idx <= '0;
          end
        end
        RX_START:
        begin
          if (mid && rx_sync)
            state <= RX_IDLE;  // glitch, not a start bit
          else if (bit_end)
            state <= RX_DATA;
        end
        RX_DATA:
        begin
          if (bit_end)
          begin
            if (bit_idx == BIT_LAST)
              state <= i_cfg.parity_en ? RX_PARITY : RX_STOP;
            else
              bit_idx <= bit_idx + 1'b1;
          end
        end
        RX_PARITY:
        begin
          if (bit_end)
            state <= RX_STOP;
        end
        RX_STOP:
        begin
          if (mid)
          begin
            // report at mid stop, byte goes out even with errors
            o_rx_valid             <= 1'b1;
            o_rx_status.parity_err <= i_cfg.parity_en && (par_bit != par_exp);
            o_rx_status.frame_err  <= !vote;
            state                  <= RX_WAIT;
          end
        end
        RX_WAIT:
        begin
          if (rx_sync)
            state <= RX_IDLE;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // sample history and received payload
  always_ff @(posedge i_clk_div_ref_clk)
  begin
    hist <= {hist[0], rx_sync};
    if ((state == RX_DATA) && mid)
      shreg <= {vote, shreg[DATA_W-1:1]};  // lsb arrives first
    if ((state == RX_PARITY) && mid)
      par_bit <= vote;
    if ((state == RX_STOP) && mid)
      o_rx_data <= shreg;
  end

endmodule

`default_nettype wire

// ==== hw/uart_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// uart subsystem top
// one divider makes the oversample clock, tx and rx both run on it
// serial loopback is left to the outside
module uart_top #(
  parameter int PRESCALE = 8  // oversample cycles per bit, passed to tx and rx
) (
  input  logic                      i_clk_div_ref_clk,
  input  logic                      i_clk_div_rst,
  input  logic                      i_clk_div_clk_en,
  input  uart_pkg::uart_ratio_t     i_clk_div_ratio,
  input  uart_pkg::uart_cfg_t       i_cfg,
  input  uart_pkg::uart_data_t      i_tx_data,
  input  logic                      i_tx_valid,
  output logic                      o_tx_serial,
  output logic                      o_tx_busy,
  input  logic                      i_rx_serial,
  output uart_pkg::uart_data_t      o_rx_data,
  output logic                      o_rx_valid,
  output uart_pkg::uart_rx_status_t o_rx_status
);

  logic os_clk;  // oversample clock, or the reference clock in bypass

  uart_clk_div uart_clk_div_inst (
    .i_clk_div_ref_clk  (i_clk_div_ref_clk),
    .i_clk_div_rst      (i_clk_div_rst),
    .i_clk_div_clk_en   (i_clk_div_clk_en),
    .i_clk_div_ratio    (i_clk_div_ratio),
    .o_clk_div_baud_clk (os_clk)
  );

  uart_tx #(
    .PRESCALE (PRESCALE)
  ) uart_tx_inst (
    .i_clk_div_ref_clk (os_clk),  // tx runs on the oversample clock
    .i_clk_div_rst     (i_clk_div_rst),
    .i_cfg             (i_cfg),
    .i_tx_data         (i_tx_data),
    .i_tx_valid        (i_tx_valid),
    .o_tx_serial       (o_tx_serial),
    .o_tx_busy         (o_tx_busy)
  );

  uart_rx #(
    .PRESCALE (PRESCALE)
  ) uart_rx_inst (
    .i_clk_div_ref_clk (os_clk),  // same clock as tx
    .i_clk_div_rst     (i_clk_div_rst),
    .i_cfg             (i_cfg),
    .i_rx_serial       (i_rx_serial),
    .o_rx_data         (o_rx_data),
    .o_rx_valid        (o_rx_valid),
    .o_rx_status       (o_rx_status)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

// reference clock and power-on reset for the testbench
module tb_clk_gen #(
  parameter int HALF_NS    = 50,  // 100 ns period
  parameter int RST_CYCLES = 10
) (
  output logic o_clk,
  output logic o_rst
);

  initial
  begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

  initial
  begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;  // released on a rising edge like every other input
  end

endmodule

`default_nettype wire

// ==== sim/uart_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

// port level checks on uart_top, all on the reference clock
module uart_sva (
  input logic                  i_clk_div_ref_clk,
  input logic                  i_clk_div_rst,
  input logic                  i_clk_div_clk_en,
  input uart_pkg::uart_ratio_t i_clk_div_ratio,
  input logic                  i_tx_valid,
  input logic                  o_tx_serial,
  input logic                  o_tx_busy,
  input logic                  o_rx_valid
);

  import uart_pkg::*;

  int valid_run;  // reference cycles o_rx_valid has been high
  int pulse_max;  // one oversample cycle, counted in reference cycles

  assign pulse_max = (i_clk_div_clk_en && (i_clk_div_ratio > uart_ratio_t'(1)))
                     ? int'(i_clk_div_ratio) : 1;

  // counted on the falling edge, so it is settled for the rising edge checks
  always_ff @(negedge i_clk_div_ref_clk or posedge i_clk_div_rst)
  begin
    if (i_clk_div_rst)
      valid_run <= 0;
    else
      valid_run <= o_rx_valid ? valid_run + 1 : 0;
  end

  idle_line_high: assert property (@(posedge i_clk_div_ref_clk) disable iff (i_clk_div_rst)
    !o_tx_busy |-> o_tx_serial)
    else $error("tx line low while tx is not busy");

  rx_pulse_width: assert property (@(posedge i_clk_div_ref_clk) disable iff (i_clk_div_rst)
    valid_run <= pulse_max)
    else $error("o_rx_valid held longer than one oversample cycle");

  busy_needs_valid: assert property (@(posedge i_clk_div_ref_clk) disable iff (i_clk_div_rst)
    $rose(o_tx_busy) |-> i_tx_valid)
    else $error("o_tx_busy rose with no request");

endmodule

bind uart_top uart_sva uart_sva_inst (
  .i_clk_div_ref_clk (i_clk_div_ref_clk),
  .i_clk_div_rst     (i_clk_div_rst),
  .i_clk_div_clk_en  (i_clk_div_clk_en),
  .i_clk_div_ratio   (i_clk_div_ratio),
  .i_tx_valid        (i_tx_valid),
  .o_tx_serial       (o_tx_serial),
  .o_tx_busy         (o_tx_busy),
  .o_rx_valid        (o_rx_valid)
);

`default_nettype wire

// ==== sim/uart_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

// table driven loopback test of uart_top, tx line fed back into rx
module uart_tb;

  import uart_pkg::*;

  localparam int         PRESCALE   = 8;
  localparam int         N_ROWS     = 12;
  localparam logic [1:0] INJ_NONE   = 2'd0;
  localparam logic [1:0] INJ_PARITY = 2'd1;  // parity bit inverted on the line
  localparam logic [1:0] INJ_STOP   = 2'd2;  // stop bit forced low on the line

  typedef struct packed {
    uart_ratio_t ratio;
    logic        en;
    uart_cfg_t   cfg;     // {parity_en, parity_odd}
    uart_data_t  data;
    logic [1:0]  inject;
  } row_t;

  logic            clk;
  logic            gen_rst;
  logic            row_rst;
  logic            dut_rst;
  logic            clk_en;
  uart_ratio_t     ratio;
  uart_cfg_t       cfg;
  uart_data_t      tx_data;
  logic            tx_valid;
  logic            rx_serial = 1'b1;
  logic            tx_serial;
  logic            tx_busy;
  uart_data_t      rx_data;
  logic            rx_valid;
  uart_rx_status_t rx_status;

  row_t            rows [N_ROWS];
  logic            table_ready = 1'b0;
  logic [31:0]     lfsr = 32'h30f14269;
  int              cur_b = PRESCALE;  // bit period in reference cycles
  int              cur_bits = 10;
  int              inj_bit = -1;      // frame bit replaced on the line, -1 for none
  logic [1:0]      cur_inject = INJ_NONE;
  logic [10:0]     frame_bits = '1;   // expected line level per bit, start bit first

  // monitor state, written only on the falling edge
  int              ncyc = 0;
  int              t_start = 0;
  int              busy_cnt = 0;
  int              low_run = 0;
  int              valid_cnt = 0;
  logic            tracking = 1'b0;
  logic            run_open = 1'b0;
  logic            prev_busy = 1'b0;
  logic            prev_valid = 1'b0;
  logic            line_next = 1'b1;
  uart_data_t      got_data;
  uart_rx_status_t got_status;

  tb_clk_gen clk_gen_inst (
    .o_clk (clk),
    .o_rst (gen_rst)
  );

  assign dut_rst = gen_rst | row_rst;

  uart_top #(
    .PRESCALE (PRESCALE)
  ) uart_top_inst (
    .i_clk_div_ref_clk (clk),
    .i_clk_div_rst     (dut_rst),
    .i_clk_div_clk_en  (clk_en),
    .i_clk_div_ratio   (ratio),
    .i_cfg             (cfg),
    .i_tx_data         (tx_data),
    .i_tx_valid        (tx_valid),
    .o_tx_serial       (tx_serial),
    .o_tx_busy         (tx_busy),
    .i_rx_serial       (rx_serial),
    .o_rx_data         (rx_data),
    .o_rx_valid        (rx_valid),
    .o_rx_status       (rx_status)
  );

  // galois step, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic next_byte(output uart_data_t b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_step(lfsr);  // one step per bit taken
      b[i] = lfsr[0];
    end
  endtask

  function automatic int bit_period(input row_t r);
    if (r.en && (r.ratio > uart_ratio_t'(1)))
      return PRESCALE * int'(r.ratio);
    return PRESCALE;  // bypass runs on the reference clock
  endfunction

  function automatic logic [10:0] frame_of(input row_t r);
    logic [10:0] f;
    f = {2'b11, r.data, 1'b0};  // stop, data lsb first, start
    if (r.cfg.parity_en)
      f[9] = (^r.data) ^ r.cfg.parity_odd;  // even or odd count of ones incl parity
    return f;
  endfunction

  function automatic uart_rx_status_t status_of(input row_t r);
    uart_rx_status_t s;
    s.parity_err = (r.inject == INJ_PARITY);
    s.frame_err  = (r.inject == INJ_STOP);
    return s;
  endfunction

  // bits low in a row from the start bit on
  function automatic int first_low_run(input logic [10:0] f, input int nbits);
    int n;
    n = 0;
    while ((n < nbits) && !f[n])
      n++;
    return n;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input string name, input uart_data_t got, input uart_data_t exp);
    if (got !== exp)
      report_error($sformatf("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp));
  endtask

  task automatic check_status(input string name, input uart_rx_status_t got,
                              input uart_rx_status_t exp);
    if (got !== exp)
      report_error($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      report_error($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_error($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // falling edge monitor, outputs are settled here
  always @(negedge clk)
  begin
    int off;
    off = ncyc - t_start;
    if (dut_rst)
    begin
      tracking  = 1'b0;
      valid_cnt = 0;
      busy_cnt  = 0;
    end
    else if (tx_busy && !prev_busy)
    begin
      t_start  = ncyc;  // start bit goes out with busy
      off      = 0;
      tracking = 1'b1;
      run_open = 1'b1;
      low_run  = 0;
    end
    if (tracking && (off < cur_bits * cur_b))
    begin
      check_level("o_tx_serial", tx_serial, frame_bits[off / cur_b]);
      if (run_open && !tx_serial)
        low_run++;
      else
        run_open = 1'b0;
    end
    if (tx_busy)
      busy_cnt++;
    line_next = tx_serial;
    if (tracking && ((off / cur_b) == inj_bit))
      line_next = (cur_inject == INJ_STOP) ? 1'b0 : ~tx_serial;
    if (rx_valid && !prev_valid)
    begin
      valid_cnt++;
      got_data   = rx_data;
      got_status = rx_status;
    end
    prev_busy  = tx_busy;
    prev_valid = rx_valid;
    ncyc++;
  end

  always @(posedge clk)
    rx_serial <= line_next;  // loopback, half a cycle behind the line

  task automatic run_row(input row_t r);
    @(posedge clk);
    row_rst    <= 1'b1;
    clk_en     <= r.en;
    ratio      <= r.ratio;
    cfg        <= r.cfg;
    tx_data    <= r.data;
    cur_b      = bit_period(r);
    cur_bits   = r.cfg.parity_en ? 11 : 10;
    frame_bits = frame_of(r);
    cur_inject = r.inject;
    inj_bit    = (r.inject == INJ_PARITY) ? 9 : ((r.inject == INJ_STOP) ? cur_bits - 1 : -1);
    repeat (2) @(posedge clk);
    check_level("o_tx_serial", tx_serial, 1'b1);  // reset values
    check_level("o_tx_busy", tx_busy, 1'b0);
    check_level("o_rx_valid", rx_valid, 1'b0);
    check_status("o_rx_status", rx_status, '0);
    row_rst <= 1'b0;
    repeat (2) @(posedge clk);
    tx_valid <= 1'b1;
    do
      @(posedge clk);
    while (!tracking);  // busy seen high
    tx_valid <= 1'b0;
    while (valid_cnt == 0)
      @(posedge clk);
    while (prev_busy)
      @(posedge clk);
    repeat (cur_b) @(posedge clk);  // room for a stray pulse
    check_data("o_rx_data", got_data, r.data);
    check_status("o_rx_status", got_status, status_of(r));
    check_count("o_tx_busy cycles", busy_cnt, cur_bits * cur_b);
    check_count("start bit low run", low_run, first_low_run(frame_bits, cur_bits) * cur_b);
    check_count("o_rx_valid pulses", valid_cnt, 1);
  endtask

  initial
  begin
    uart_data_t b;
    row_rst  = 1'b1;
    clk_en   = 1'b0;
    ratio    = '0;
    cfg      = '0;
    tx_data  = '0;
    tx_valid = 1'b0;
    rows[0]  = '{20'd4, 1'b1, 2'b00, 8'h00, INJ_NONE};
    rows[1]  = '{20'd4, 1'b1, 2'b10, 8'hff, INJ_NONE};
    next_byte(b);
    rows[2]  = '{20'd5, 1'b1, 2'b11, b, INJ_NONE};
    next_byte(b);
    rows[3]  = '{20'd3, 1'b1, 2'b00, b, INJ_NONE};
    rows[4]  = '{20'd0, 1'b1, 2'b10, 8'h55, INJ_NONE};
    rows[5]  = '{20'd1, 1'b1, 2'b11, 8'ha5, INJ_NONE};
    next_byte(b);
    rows[6]  = '{20'd6, 1'b0, 2'b00, b, INJ_NONE};  // divider off, bypass
    next_byte(b);
    rows[7]  = '{20'd2, 1'b1, 2'b10, b, INJ_PARITY};
    next_byte(b);
    rows[8]  = '{20'd7, 1'b1, 2'b11, b, INJ_PARITY};
    next_byte(b);
    rows[9]  = '{20'd4, 1'b1, 2'b00, b, INJ_STOP};
    rows[10] = '{20'd3, 1'b1, 2'b10, 8'h80, INJ_STOP};
    rows[11] = '{20'd0, 1'b0, 2'b11, 8'h01, INJ_NONE};
    table_ready = 1'b1;
    while (gen_rst)
      @(posedge clk);
    for (int i = 0; i < N_ROWS; i++)
      run_row(rows[i]);
    $display("Everything OK");
    $finish;
  end

  // watchdog, twelve bit periods per row plus slack
  initial
  begin
    int limit;
    limit = 200;
    wait (table_ready);
    for (int i = 0; i < N_ROWS; i++)
      limit += 12 * bit_period(rows[i]) + 64;
    repeat (limit) @(posedge clk);
    report_error("timeout: the frames did not complete within the expected time");
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/uart_pkg.sv
hw/uart_clk_div.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
sim/tb_clk_gen.sv
sim/uart_sva.sv
sim/uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the uart testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module uart_tb -f tb.f -o uart_sim \
  && ./obj_dir/uart_sim | tee /dev/stderr | grep -qx "Everything OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
